/* lsu_pkg.sv */
// load/store unit shared definitions
// widths, access size and sign mode encodings, outstanding depth
package lsu_pkg;

  ////////////////////////////////////////
  // widths
  ////////////////////////////////////////

  typedef logic [31:0] word_t;      // data or address word
  typedef logic [3:0]  be_t;        // byte enables, one per byte lane
  typedef logic [1:0]  byte_off_t;  // byte offset inside a word
  typedef logic [1:0]  cnt_t;       // outstanding transaction count

  ////////////////////////////////////////
  // encodings
  ////////////////////////////////////////

  // access size, both upper codes select a byte
  typedef enum logic [1:0] {
    DT_WORD     = 2'b00,
    DT_HALF     = 2'b01,
    DT_BYTE     = 2'b10,
    DT_BYTE_ALT = 2'b11
  } data_type_e;

  // extension of loaded half words and bytes
  typedef enum logic [1:0] {
    SIGN_ZERO = 2'b00,  // upper bits cleared
    SIGN_EXT  = 2'b01,  // upper bits copy the msb
    SIGN_ONES = 2'b10   // upper bits set
  } sign_mode_e;

  ////////////////////////////////////////
  // limits
  ////////////////////////////////////////

  // max transactions between acceptance and rvalid
  localparam int unsigned LSU_DEPTH = 2;

  // control queue pointer width, queue depth is a power of two
  localparam int unsigned LSU_PTR_W = $clog2(LSU_DEPTH);

endpackage

/* lsu_req_if.sv */
// bus transaction from the address stage to the bus stage
// valid/ready handshake, one transfer per cycle with both high
`timescale 1ns/1ps

interface lsu_req_if;
  import lsu_pkg::*;

  logic  valid;  // aligned request present
  logic  ready;  // bus stage can take it
  word_t addr;   // byte address
  logic  we;     // store when high
  be_t   be;     // byte enables
  word_t wdata;  // rotated store data

  // address stage side
  modport source (
    output valid, addr, we, be, wdata,
    input  ready
  );

  // bus stage side
  modport sink (
    input  valid, addr, we, be, wdata,
    output ready
  );

endinterface

/* lsu_ctrl_if.sv */
// per-transaction control from the address stage to the read-data stage
// push marks the cycle a request moves to the bus stage
`timescale 1ns/1ps

interface lsu_ctrl_if;
  import lsu_pkg::*;

  logic       push;       // request accepted this cycle
  data_type_e data_type;  // access size
  byte_off_t  offset;     // address offset in the word
  sign_mode_e sign_mode;  // load extension mode
  logic       we;         // store, no data to align

  // address stage side
  modport source (
    output push, data_type, offset, sign_mode, we
  );

  // read-data stage side, no back-pressure
  modport sink (
    input  push, data_type, offset, sign_mode, we
  );

endinterface

/* lsu_addr_stage.sv */
// lsu address stage
// forms the address, byte enables and rotated store data from the core
// request, flags misaligned accesses and pushes per-access control
`timescale 1ns/1ps

module lsu_addr_stage (
  input  lsu_pkg::word_t      operand_a_i,
  input  lsu_pkg::word_t      operand_b_i,
  input  lsu_pkg::word_t      wdata_i,
  input  logic                addr_incr_i,   // a + b when high, else a alone
  input  logic                we_i,
  input  logic                req_i,
  input  lsu_pkg::data_type_e data_type_i,
  input  lsu_pkg::sign_mode_e sign_mode_i,
  input  lsu_pkg::byte_off_t  reg_offset_i,  // byte position of data in the register
  output logic                ready_o,
  output logic                misaligned_o,
  lsu_req_if.source           req_mp,
  lsu_ctrl_if.source          ctrl_mp
);
  import lsu_pkg::*;

  word_t     addr;
  byte_off_t addr_off;
  byte_off_t wdata_off;  // rotation amount in bytes
  be_t       be;
  word_t     wdata_rot;

  ////////////////////////////////////////
  // address and byte enables
  ////////////////////////////////////////

  assign addr     = addr_incr_i ? (operand_a_i + operand_b_i) : operand_a_i;
  assign addr_off = addr[1:0];

  // lanes start at the offset and cover the access size
  always_comb begin
    case (data_type_i)
      DT_WORD: be = be_t'(4'b1111 << addr_off);
      DT_HALF: be = be_t'(4'b0011 << addr_off);
      default: be = be_t'(4'b0001 << addr_off);  // both byte codes
    endcase
  end

  // word off a word boundary, or half crossing it
  always_comb begin
    misaligned_o = 1'b0;
    if (req_i) begin
      case (data_type_i)
        DT_WORD: misaligned_o = (addr_off != 2'b00);
        DT_HALF: misaligned_o = (addr_off == 2'b11);
        default: misaligned_o = 1'b0;  // bytes always fit
      endcase
    end
  end

  ////////////////////////////////////////
  // store data rotation
  ////////////////////////////////////////

  // move the register bytes onto the addressed lanes
  assign wdata_off = addr_off - reg_offset_i;

  always_comb begin
    case (wdata_off)
      2'b00:   wdata_rot = wdata_i;
      2'b01:   wdata_rot = {wdata_i[23:0], wdata_i[31:24]};
      2'b10:   wdata_rot = {wdata_i[15:0], wdata_i[31:16]};
      default: wdata_rot = {wdata_i[7:0],  wdata_i[31:8]};
    endcase
  end

  ////////////////////////////////////////
  // request and control outputs
  ////////////////////////////////////////

  assign req_mp.valid = req_i && !misaligned_o;  // misaligned never reaches the bus
  assign req_mp.addr  = addr;
  assign req_mp.we    = we_i;
  assign req_mp.be    = be;
  assign req_mp.wdata = wdata_rot;

  // misaligned requests are consumed at once
  assign ready_o = misaligned_o || req_mp.ready;

  assign ctrl_mp.push      = req_mp.valid && req_mp.ready;
  assign ctrl_mp.data_type = data_type_i;
  assign ctrl_mp.offset    = addr_off;
  assign ctrl_mp.sign_mode = sign_mode_i;
  assign ctrl_mp.we        = we_i;

endmodule

/* lsu_bus_stage.sv */
// lsu bus stage
// holds one data-bus request stable until grant and counts
// transactions from acceptance to rvalid against LSU_DEPTH
`timescale 1ns/1ps

module lsu_bus_stage (
  input  logic            clk,
  input  logic            rst_n,
  lsu_req_if.sink         req_mp,
  output logic            data_req_o,
  output logic            data_we_o,
  output lsu_pkg::word_t  data_addr_o,
  output lsu_pkg::word_t  data_wdata_o,
  output lsu_pkg::be_t    data_be_o,
  input  logic            data_gnt_i,
  input  logic            data_rvalid_i,
  input  lsu_pkg::word_t  data_rdata_i,
  output logic            rsp_valid_o,
  output lsu_pkg::word_t  rsp_rdata_o,
  output logic            busy_o
);
  import lsu_pkg::*;

  logic  req_q;    // request held for the bus
  cnt_t  cnt_q;    // accepted and not yet answered
  cnt_t  cnt_d;
  logic  accept;   // handshake on req_mp
  word_t addr_q;
  word_t wdata_q;
  be_t   be_q;
  logic  we_q;

  ////////////////////////////////////////
  // acceptance
  ////////////////////////////////////////

  // room in the count, and the holding slot is free or frees now
  assign req_mp.ready = (cnt_q < cnt_t'(LSU_DEPTH)) && (!req_q || data_gnt_i);
  assign accept       = req_mp.valid && req_mp.ready;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      req_q <= 1'b0;
    end else if (accept) begin
      req_q <= 1'b1;               // new request replaces a granted one
    end else if (data_gnt_i) begin
      req_q <= 1'b0;
    end
  end

  // request fields, loaded only on acceptance so they hold until grant
  always_ff @(posedge clk) begin
    if (accept) begin
      addr_q  <= req_mp.addr;
      wdata_q <= req_mp.wdata;
      be_q    <= req_mp.be;
      we_q    <= req_mp.we;
    end
  end

  ////////////////////////////////////////
  // outstanding counter
  ////////////////////////////////////////

  always_comb begin
    case ({accept, data_rvalid_i})
      2'b10:   cnt_d = cnt_q + cnt_t'(1);
      2'b01:   cnt_d = cnt_q - cnt_t'(1);
      default: cnt_d = cnt_q;      // idle, or one in and one out
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt_q <= '0;
    end else begin
      cnt_q <= cnt_d;
    end
  end

  ////////////////////////////////////////
  // bus and response outputs
  ////////////////////////////////////////

  assign data_req_o   = req_q;
  assign data_addr_o  = addr_q;
  assign data_wdata_o = wdata_q;
  assign data_be_o    = be_q;
  assign data_we_o    = we_q;

  assign rsp_valid_o  = data_rvalid_i;  // responses come back in order
  assign rsp_rdata_o  = data_rdata_i;

  assign busy_o = (cnt_q != '0) || req_q;

endmodule

/* lsu_rdata_stage.sv */
// lsu read-data stage
// queues the control of each transaction in flight and, when its
// response returns, shifts the addressed bytes down and extends them
`timescale 1ns/1ps

module lsu_rdata_stage (
  input  logic           clk,
  input  logic           rst_n,
  lsu_ctrl_if.sink       ctrl_mp,
  input  logic           rsp_valid_i,
  input  lsu_pkg::word_t rsp_rdata_i,
  output logic           resp_valid_o,
  output lsu_pkg::word_t resp_rdata_o
);
  import lsu_pkg::*;

  // control queue storage
  data_type_e           q_type [LSU_DEPTH];
  byte_off_t            q_off  [LSU_DEPTH];
  sign_mode_e           q_sign [LSU_DEPTH];
  logic                 q_we   [LSU_DEPTH];
  logic [LSU_PTR_W-1:0] wr_ptr_q;
  logic [LSU_PTR_W-1:0] rd_ptr_q;

  // head of queue, belongs to the response on the bus
  data_type_e head_type;
  byte_off_t  head_off;
  sign_mode_e head_sign;
  logic       head_we;

  word_t rdata_shift;  // addressed bytes moved to lane 0
  logic  fill_h;       // upper fill for half words
  logic  fill_b;       // upper fill for bytes
  word_t rdata_ext;

  ////////////////////////////////////////
  // control queue
  ////////////////////////////////////////

  // entries carry no reset, pointers do
  always_ff @(posedge clk) begin
    if (ctrl_mp.push) begin
      q_type[wr_ptr_q] <= ctrl_mp.data_type;
      q_off[wr_ptr_q]  <= ctrl_mp.offset;
      q_sign[wr_ptr_q] <= ctrl_mp.sign_mode;
      q_we[wr_ptr_q]   <= ctrl_mp.we;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
    end else begin
      if (ctrl_mp.push) wr_ptr_q <= wr_ptr_q + 1'b1;  // wraps at LSU_DEPTH
      if (rsp_valid_i)  rd_ptr_q <= rd_ptr_q + 1'b1;  // one pop per response
    end
  end

  assign head_type = q_type[rd_ptr_q];
  assign head_off  = q_off[rd_ptr_q];
  assign head_sign = q_sign[rd_ptr_q];
  assign head_we   = q_we[rd_ptr_q];

  ////////////////////////////////////////
  // alignment and extension
  ////////////////////////////////////////

  assign rdata_shift = rsp_rdata_i >> {head_off, 3'b000};

  always_comb begin
    case (head_sign)
      SIGN_ZERO: begin
        fill_h = 1'b0;
        fill_b = 1'b0;
      end
      SIGN_ONES: begin
        fill_h = 1'b1;
        fill_b = 1'b1;
      end
      default: begin               // sign extend, unused code too
        fill_h = rdata_shift[15];
        fill_b = rdata_shift[7];
      end
    endcase
  end

  always_comb begin
    case (head_type)
      DT_WORD: rdata_ext = rdata_shift;  // aligned words only
      DT_HALF: rdata_ext = {{16{fill_h}}, rdata_shift[15:0]};
      default: rdata_ext = {{24{fill_b}}, rdata_shift[7:0]};
    endcase
  end

  ////////////////////////////////////////
  // response to the core
  ////////////////////////////////////////

  assign resp_valid_o = rsp_valid_i;
  assign resp_rdata_o = head_we ? rsp_rdata_i : rdata_ext;  // stores pass the raw word

endmodule

/* lsu_top.sv */
// load/store unit top level
// address stage, bus stage and read-data stage behind plain core and
// data-bus ports
`timescale 1ns/1ps

module lsu_top (
  input  logic                clk,
  input  logic                rst_n,
  // core request
  input  logic                req_i,
  input  lsu_pkg::word_t      operand_a_i,
  input  lsu_pkg::word_t      operand_b_i,
  input  logic                addr_incr_i,
  input  logic                we_i,
  input  lsu_pkg::data_type_e data_type_i,
  input  lsu_pkg::sign_mode_e sign_mode_i,
  input  lsu_pkg::byte_off_t  reg_offset_i,
  input  lsu_pkg::word_t      wdata_i,
  output logic                ready_o,
  output logic                misaligned_o,
  // core response
  output logic                resp_valid_o,
  output lsu_pkg::word_t      resp_rdata_o,
  output logic                busy_o,
  // data bus
  output logic                data_req_o,
  input  logic                data_gnt_i,
  input  logic                data_rvalid_i,
  output lsu_pkg::word_t      data_addr_o,
  output logic                data_we_o,
  output lsu_pkg::be_t        data_be_o,
  output lsu_pkg::word_t      data_wdata_o,
  input  lsu_pkg::word_t      data_rdata_i
);
  import lsu_pkg::*;

  lsu_req_if  req_bus ();   // address stage to bus stage
  lsu_ctrl_if ctrl_bus ();  // address stage to read-data stage

  logic  rsp_valid;
  word_t rsp_rdata;

  lsu_addr_stage u_addr (
    .operand_a_i  (operand_a_i),
    .operand_b_i  (operand_b_i),
    .wdata_i      (wdata_i),
    .addr_incr_i  (addr_incr_i),
    .we_i         (we_i),
    .req_i        (req_i),
    .data_type_i  (data_type_i),
    .sign_mode_i  (sign_mode_i),
    .reg_offset_i (reg_offset_i),
    .ready_o      (ready_o),
    .misaligned_o (misaligned_o),
    .req_mp       (req_bus),
    .ctrl_mp      (ctrl_bus)
  );

  lsu_bus_stage u_bus (
    .clk           (clk),
    .rst_n         (rst_n),
    .req_mp        (req_bus),
    .data_req_o    (data_req_o),
    .data_we_o     (data_we_o),
    .data_addr_o   (data_addr_o),
    .data_wdata_o  (data_wdata_o),
    .data_be_o     (data_be_o),
    .data_gnt_i    (data_gnt_i),
    .data_rvalid_i (data_rvalid_i),
    .data_rdata_i  (data_rdata_i),
    .rsp_valid_o   (rsp_valid),
    .rsp_rdata_o   (rsp_rdata),
    .busy_o        (busy_o)
  );

  lsu_rdata_stage u_rdata (
    .clk          (clk),
    .rst_n        (rst_n),
    .ctrl_mp      (ctrl_bus),
    .rsp_valid_i  (rsp_valid),
    .rsp_rdata_i  (rsp_rdata),
    .resp_valid_o (resp_valid_o),
    .resp_rdata_o (resp_rdata_o)
  );

endmodule

/* lsu_checker.sv */
// bus stage checker
// properties on the held data-bus request and the outstanding count
`timescale 1ns/1ps

module lsu_checker (
  input logic           clk,
  input logic           rst_n,
  input lsu_pkg::cnt_t  cnt_i,
  input logic           data_req_i,
  input logic           data_gnt_i,
  input logic           data_rvalid_i,
  input logic           data_we_i,
  input lsu_pkg::word_t data_addr_i,
  input lsu_pkg::word_t data_wdata_i,
  input lsu_pkg::be_t   data_be_i
);
  import lsu_pkg::*;

  int unsigned fail_cnt = 0;

  // count stays within the depth limit
  cnt_bound: assert property (@(posedge clk) disable iff (!rst_n)
    cnt_i <= cnt_t'(LSU_DEPTH))
    else begin
      $error("outstanding count above the depth limit");
      fail_cnt++;
    end

  // a response needs a transaction in flight
  rvalid_owned: assert property (@(posedge clk) disable iff (!rst_n)
    data_rvalid_i |-> (cnt_i != '0))
    else begin
      $error("rvalid with no transaction outstanding");
      fail_cnt++;
    end

  // held request keeps all its fields until grant
  req_stable: assert property (@(posedge clk) disable iff (!rst_n)
    (data_req_i && !data_gnt_i) |=> (data_req_i && $stable(data_addr_i) &&
      $stable(data_we_i) && $stable(data_be_i) && $stable(data_wdata_i)))
    else begin
      $error("request dropped or changed before grant");
      fail_cnt++;
    end

  addr_known: assert property (@(posedge clk) disable iff (!rst_n)
    data_req_i |-> !$isunknown(data_addr_i))
    else begin
      $error("unknown address on a data-bus request");
      fail_cnt++;
    end

endmodule

/* tb_clk.sv */
// testbench clock and reset
// 4 ns clock, reset held low over the first three rising edges
`timescale 1ns/1ps

module tb_clk (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #2 clk_o = ~clk_o;  // 4 ns period
  end

  initial begin
    rst_n_o = 1'b0;
    repeat (3) @(posedge clk_o);
    rst_n_o <= 1'b1;            // released on the third edge
  end

endmodule

/* tb_monitor.sv */
// load/store unit monitor
// predicts bus requests and load data from the core requests, compares
// them on the DUT ports and prints one line per finished access
`timescale 1ns/1ps

module tb_monitor #(
  parameter int MAX_ACC   = 64,
  parameter int MEM_WORDS = 64
) (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                req_i,
  input  lsu_pkg::word_t      operand_a_i,
  input  lsu_pkg::word_t      operand_b_i,
  input  logic                addr_incr_i,
  input  logic                we_i,
  input  lsu_pkg::data_type_e data_type_i,
  input  lsu_pkg::sign_mode_e sign_mode_i,
  input  lsu_pkg::byte_off_t  reg_offset_i,
  input  lsu_pkg::word_t      wdata_i,
  input  logic                ready_i,
  input  logic                misaligned_i,
  input  logic                resp_valid_i,
  input  lsu_pkg::word_t      resp_rdata_i,
  input  logic                busy_i,
  input  logic                data_req_i,
  input  logic                data_gnt_i,
  input  logic                data_we_i,
  input  lsu_pkg::word_t      data_addr_i,
  input  lsu_pkg::be_t        data_be_i,
  input  lsu_pkg::word_t      data_wdata_i,
  output int                  done_o,
  output int                  failed_o,
  output int                  errors_o,
  output int                  inflight_o
);
  import lsu_pkg::*;

  typedef struct packed {
    logic [15:0] id;
    logic        we;
    word_t       addr;
    be_t         be;
    word_t       wdata;
    word_t       rdata;  // expected load result
  } exp_t;

  exp_t  bus_q [$];           // accepted, waiting for grant
  exp_t  rsp_q [$];           // accepted, waiting for response
  word_t shadow [MEM_WORDS];  // memory as the core sees it
  int    bad [MAX_ACC];       // mismatches per access
  int    n_hs, accepted, granted, responded;
  int    done, failed, errors;

  ////////////////////////////////////////
  // reference rules
  ////////////////////////////////////////

  function automatic word_t fill_word(input int idx);
    return (idx * 32'h9e37_79b9) ^ 32'h5a5a_c3c3;
  endfunction

  function automatic int word_index(input word_t addr);
    return int'((addr >> 2) % MEM_WORDS);
  endfunction

  // lanes from the offset up to the access size
  function automatic be_t expect_be(input data_type_e dt, input byte_off_t off);
    int  n;
    be_t be;
    n = (dt == DT_WORD) ? 4 : ((dt == DT_HALF) ? 2 : 1);
    for (int k = 0; k < 4; k++) be[k] = (k >= off) && (k < off + n);
    return be;
  endfunction

  function automatic word_t rotate_bytes(input word_t w, input byte_off_t r);
    logic [63:0] twice;
    twice = {w, w} << (8 * r);
    return twice[63:32];
  endfunction

  function automatic word_t extend_load(input word_t w, input data_type_e dt,
                                        input byte_off_t off, input sign_mode_e sm);
    word_t lane;
    word_t mask;
    logic  fill;
    lane = w >> (8 * off);
    if (dt == DT_WORD) return lane;
    mask = (dt == DT_HALF) ? 32'h0000_ffff : 32'h0000_00ff;
    case (sm)
      SIGN_ZERO: fill = 1'b0;
      SIGN_ONES: fill = 1'b1;
      default:   fill = (dt == DT_HALF) ? lane[15] : lane[7];  // top loaded bit
    endcase
    return (lane & mask) | (fill ? ~mask : 32'h0);
  endfunction

  task automatic report_mismatch(input string what, input word_t got, input word_t exp,
                                 input int id);
    $display("[FAIL] %0t: access %0d %s, got %08h expected %08h", $time, id, what, got, exp);
    errors++;
    if (id < MAX_ACC) bad[id]++;
  endtask

  task automatic finish_test(input int id, input string kind, input word_t addr);
    done++;
    if (bad[id] != 0) failed++;
    $display("access %0d %s at %08h: %s", id, kind, addr, (bad[id] != 0) ? "mismatch" : "ok");
  endtask

  initial begin
    for (int i = 0; i < MEM_WORDS; i++) shadow[i] = fill_word(i);
  end

  ////////////////////////////////////////
  // per-cycle checks
  ////////////////////////////////////////

  always @(posedge clk) begin
    exp_t      e;
    word_t     addr;
    byte_off_t off;
    logic      mis;
    int        id;
    if (rst_n) begin
      // busy mirrors transactions accepted and not yet answered
      if (busy_i !== (accepted != responded)) begin
        $display("[FAIL] %0t: busy_o is %b with %0d transactions in flight",
                 $time, busy_i, accepted - responded);
        errors++;
      end
      if (data_req_i && data_gnt_i) begin
        if (bus_q.size() == 0) begin
          $display("bus grant at %0t with no request expected", $time);
          errors++;
        end else begin
          e = bus_q.pop_front();
          granted++;
          if (data_addr_i !== e.addr) report_mismatch("address", data_addr_i, e.addr, e.id);
          if (data_be_i !== e.be)
            report_mismatch("byte enables", word_t'(data_be_i), word_t'(e.be), e.id);
          if (data_we_i !== e.we)
            report_mismatch("write enable", word_t'(data_we_i), word_t'(e.we), e.id);
          if (e.we && data_wdata_i !== e.wdata)
            report_mismatch("write data", data_wdata_i, e.wdata, e.id);
        end
      end
      if (resp_valid_i) begin
        if (rsp_q.size() == 0) begin
          $display("response at %0t with no access outstanding", $time);
          errors++;
        end else begin
          e = rsp_q.pop_front();      // in order
          responded++;
          if (!e.we && resp_rdata_i !== e.rdata)
            report_mismatch("load data", resp_rdata_i, e.rdata, e.id);
          finish_test(e.id, e.we ? "store" : "load", e.addr);
        end
      end
      if (granted - responded > LSU_DEPTH) begin
        $display("%0d transactions between grant and response at %0t",
                 granted - responded, $time);
        errors++;
      end
      if (req_i && ready_i) begin    // core handshake
        id   = n_hs;
        n_hs++;
        addr = addr_incr_i ? (operand_a_i + operand_b_i) : operand_a_i;
        off  = addr[1:0];
        mis  = (data_type_i == DT_WORD && off != 2'd0) ||
               (data_type_i == DT_HALF && off == 2'd3);
        if (misaligned_i !== mis)
          report_mismatch("misaligned flag", word_t'(misaligned_i), word_t'(mis), id);
        if (mis) begin
          finish_test(id, "misaligned", addr);
        end else begin
          e.id    = 16'(id);
          e.we    = we_i;
          e.addr  = addr;
          e.be    = expect_be(data_type_i, off);
          e.wdata = rotate_bytes(wdata_i, off - reg_offset_i);
          e.rdata = extend_load(shadow[word_index(addr)], data_type_i, off, sign_mode_i);
          if (we_i) begin
            for (int k = 0; k < 4; k++)
              if (e.be[k]) shadow[word_index(addr)][8*k +: 8] = e.wdata[8*k +: 8];
          end
          bus_q.push_back(e);
          rsp_q.push_back(e);
          accepted++;
        end
      end
    end
    done_o     <= done;
    failed_o   <= failed;
    errors_o   <= errors;
    inflight_o <= accepted - responded;
  end

endmodule

/* tb_top.sv */
// load/store unit testbench top
// reads accesses from the data file, drives the core side and models a
// data memory with random grant and response delays
`timescale 1ns/1ps

module tb_top;
  import lsu_pkg::*;

  localparam int NUM_COLS  = 9;    // values per access line
  localparam int MAX_ACC   = 64;
  localparam int MEM_WORDS = 64;
  localparam int TIMEOUT   = 200;  // cycles per wait

  logic       clk;
  logic       rst_n;
  logic       req;
  word_t      operand_a;
  word_t      operand_b;
  logic       addr_incr;
  logic       we;
  data_type_e data_type;
  sign_mode_e sign_mode;
  byte_off_t  reg_offset;
  word_t      wdata;
  logic       ready, misaligned, resp_valid, busy;
  word_t      resp_rdata;
  logic       data_req, data_gnt, data_rvalid, data_we;
  word_t      data_addr, data_wdata, data_rdata;
  be_t        data_be;

  logic [31:0] stim [NUM_COLS*MAX_ACC];
  int          num_acc;
  word_t       mem [MEM_WORDS];    // bus side memory
  logic [31:0] rng;
  int          cyc, last_due, due, gnt_wait, gnt_delay;
  int          due_q [$];          // response edge per granted access
  word_t       rdata_q [$];
  int          mon_done, mon_failed, mon_errors, mon_inflight;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic word_t fill_word(input int idx);
    return (idx * 32'h9e37_79b9) ^ 32'h5a5a_c3c3;
  endfunction

  function automatic int word_index(input word_t addr);
    return int'((addr >> 2) % MEM_WORDS);
  endfunction

  task automatic report_timeout(input string what);
    $display("timeout at %0t after %0d cycles: %s", $time, TIMEOUT, what);
  endtask

  tb_clk u_clk (.clk_o(clk), .rst_n_o(rst_n));

  lsu_top DUT (
    .clk (clk), .rst_n (rst_n),
    .req_i (req), .operand_a_i (operand_a), .operand_b_i (operand_b),
    .addr_incr_i (addr_incr), .we_i (we), .data_type_i (data_type),
    .sign_mode_i (sign_mode), .reg_offset_i (reg_offset), .wdata_i (wdata),
    .ready_o (ready), .misaligned_o (misaligned),
    .resp_valid_o (resp_valid), .resp_rdata_o (resp_rdata), .busy_o (busy),
    .data_req_o (data_req), .data_gnt_i (data_gnt), .data_rvalid_i (data_rvalid),
    .data_addr_o (data_addr), .data_we_o (data_we), .data_be_o (data_be),
    .data_wdata_o (data_wdata), .data_rdata_i (data_rdata)
  );

  tb_monitor #(.MAX_ACC(MAX_ACC), .MEM_WORDS(MEM_WORDS)) u_monitor (
    .clk (clk), .rst_n (rst_n),
    .req_i (req), .operand_a_i (operand_a), .operand_b_i (operand_b),
    .addr_incr_i (addr_incr), .we_i (we), .data_type_i (data_type),
    .sign_mode_i (sign_mode), .reg_offset_i (reg_offset), .wdata_i (wdata),
    .ready_i (ready), .misaligned_i (misaligned),
    .resp_valid_i (resp_valid), .resp_rdata_i (resp_rdata), .busy_i (busy),
    .data_req_i (data_req), .data_gnt_i (data_gnt), .data_we_i (data_we),
    .data_addr_i (data_addr), .data_be_i (data_be), .data_wdata_i (data_wdata),
    .done_o (mon_done), .failed_o (mon_failed), .errors_o (mon_errors),
    .inflight_o (mon_inflight)
  );

  bind lsu_bus_stage lsu_checker u_checker (
    .clk           (clk),
    .rst_n         (rst_n),
    .cnt_i         (cnt_q),
    .data_req_i    (data_req_o),
    .data_gnt_i    (data_gnt_i),
    .data_rvalid_i (data_rvalid_i),
    .data_we_i     (data_we_o),
    .data_addr_i   (data_addr_o),
    .data_wdata_i  (data_wdata_o),
    .data_be_i     (data_be_o)
  );

  ////////////////////////////////////////
  // memory model
  ////////////////////////////////////////

  always @(posedge clk) begin
    if (rst_n) begin
      cyc = cyc + 1;
      data_rvalid <= 1'b0;
      if (data_req && data_gnt) begin   // access happens on the grant edge
        if (data_we) begin
          for (int k = 0; k < 4; k++)
            if (data_be[k]) mem[word_index(data_addr)][8*k +: 8] = data_wdata[8*k +: 8];
        end
        rng = xorshift32(rng);
        due = cyc + 1 + int'(rng % 3);  // 1 to 3 cycles after grant
        if (due <= last_due) due = last_due + 1;  // keep order
        last_due = due;
        due_q.push_back(due);
        rdata_q.push_back(mem[word_index(data_addr)]);
        data_gnt <= 1'b0;
        gnt_wait = 0;
        rng = xorshift32(rng);
        gnt_delay = int'(rng % 3);
      end else if (data_req) begin
        if (gnt_wait >= gnt_delay) data_gnt <= 1'b1;
        else gnt_wait++;
      end
      if (due_q.size() > 0 && due_q[0] <= cyc) begin
        data_rvalid <= 1'b1;
        data_rdata  <= rdata_q.pop_front();
        void'(due_q.pop_front());
      end
    end
  end

  ////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////

  initial begin
    int   waited;
    int   base;
    logic timed_out;
    req         = 1'b0;
    operand_a   = '0;
    operand_b   = '0;
    addr_incr   = 1'b0;
    we          = 1'b0;
    data_type   = DT_WORD;
    sign_mode   = SIGN_ZERO;
    reg_offset  = '0;
    wdata       = '0;
    data_gnt    = 1'b0;
    data_rvalid = 1'b0;
    data_rdata  = '0;
    rng         = 32'h9fc8_84ca;
    cyc         = 0;
    last_due    = 0;
    gnt_wait    = 0;
    gnt_delay   = 0;
    timed_out   = 1'b0;
    for (int i = 0; i < MEM_WORDS; i++) mem[i] = fill_word(i);
    $readmemh("lsu_testdata.txt", stim);
    num_acc = 0;
    while (num_acc < MAX_ACC && !$isunknown(stim[num_acc*NUM_COLS])) num_acc++;

    waited = 0;
    while (!rst_n && waited < TIMEOUT) begin
      @(posedge clk);
      waited++;
    end
    if (!rst_n) begin
      report_timeout("reset never released");
      timed_out = 1'b1;
    end

    for (int n = 0; n < num_acc && !timed_out; n++) begin
      base = n * NUM_COLS;
      if (stim[base] != 0) begin      // idle gap before this access
        req <= 1'b0;
        repeat (stim[base]) @(posedge clk);
      end
      req        <= 1'b1;
      we         <= stim[base+1][0];
      addr_incr  <= stim[base+2][0];
      data_type  <= data_type_e'(stim[base+3][1:0]);
      sign_mode  <= sign_mode_e'(stim[base+4][1:0]);
      reg_offset <= stim[base+5][1:0];
      operand_a  <= stim[base+6];
      operand_b  <= stim[base+7];
      wdata      <= stim[base+8];
      waited = 0;
      do begin
        @(posedge clk);
        waited++;
      end while (!ready && waited < TIMEOUT);
      if (!ready) begin
        report_timeout("ready_o never rose for a held request");
        timed_out = 1'b1;
      end
    end
    req <= 1'b0;

    // every access finished and nothing left in the DUT
    waited = 0;
    while (!timed_out && (mon_done != num_acc || mon_inflight != 0 || busy) &&
           waited < TIMEOUT) begin
      @(posedge clk);
      waited++;
    end
    if (!timed_out && (mon_done != num_acc || mon_inflight != 0 || busy)) begin
      report_timeout("responses did not drain");
      timed_out = 1'b1;
    end

    if (timed_out) begin
      $display("=== FAIL ===");
    end else begin
      @(negedge clk);  // monitor counts of the last edge settle
      $display("accesses %0d, finished %0d, failed %0d, check errors %0d, assertion errors %0d",
               num_acc, mon_done, mon_failed, mon_errors, DUT.u_bus.u_checker.fail_cnt);
      if (mon_done == num_acc && mon_failed == 0 && mon_errors == 0 &&
          DUT.u_bus.u_checker.fail_cnt == 0) begin
        $display("=== PASS ===");
      end else begin
        $display("=== FAIL ===");
      end
    end
    $finish;
  end

endmodule

/* lsu_testdata.txt */
// gap we incr type sign regoff operand_a operand_b wdata, all hex, one access per line
// gap: idle cycles before the access; type 0 word 1 half 2/3 byte; sign 0 zero 1 sign 2 ones
0 1 1 0 0 0 00000010 00000000 a1b2c3d4
0 1 1 1 0 0 00000020 00000002 00001234
0 1 0 1 0 1 00000031 00000000 0000ab00
0 1 1 2 0 0 00000040 00000003 000000ee
0 1 1 2 0 2 00000044 00000001 00ee0000
0 1 1 3 0 0 00000048 00000002 00000077
0 1 0 1 0 0 00000050 00000004 0000beef
0 0 1 0 0 0 00000010 00000000 00000000
0 0 1 1 1 0 00000020 00000002 00000000
0 0 1 2 1 0 00000040 00000003 00000000
0 0 1 2 0 0 00000040 00000003 00000000
0 0 1 1 2 0 00000030 00000001 00000000
3 0 1 0 0 0 00000060 00000001 00000000
0 1 1 1 0 0 00000060 00000003 12345678
0 0 0 0 0 0 00000062 00000000 00000000
0 0 1 0 0 0 00000000 00000004 00000000
0 0 1 1 1 0 00000008 00000002 00000000
0 0 1 2 2 0 0000000c 00000001 00000000
0 0 1 1 0 0 00000080 00000001 00000000
0 0 1 3 1 0 000000a0 00000002 00000000
c 1 1 0 0 0 00000070 00000004 cafef00d
0 0 1 0 0 0 00000074 00000000 00000000

/* tb.f */
lsu_pkg.sv
lsu_req_if.sv
lsu_ctrl_if.sv
lsu_addr_stage.sv
lsu_bus_stage.sv
lsu_rdata_stage.sv
lsu_top.sv
lsu_checker.sv
tb_clk.sv
tb_monitor.sv
tb_top.sv

/* Bender.yml */
package:
  name: lsu

sources:
  # design
  - lsu_pkg.sv
  - lsu_req_if.sv
  - lsu_ctrl_if.sv
  - lsu_addr_stage.sv
  - lsu_bus_stage.sv
  - lsu_rdata_stage.sv
  - lsu_top.sv
  # testbench
  - target: test
    files:
      - lsu_checker.sv
      - tb_clk.sv
      - tb_monitor.sv
      - tb_top.sv
